// ==== id_stage_top.f ====
+incdir+.
id_pkg.sv
id_aligner.sv
id_decoder.sv
id_hrd_ctrl.sv
id_acm_scrubber.sv
id_idop_reg.sv
id_stage_top.sv
tb_clock_gen.sv
tb_id_assertions.sv
tb_id_stage.sv

// ==== tb_id_stage.sv ====
// Decode stage testbench
// Table driven decode, bubble, flush, stall, scrub and watchdog checks

`timescale 1ns/1ps
`include "id_defines.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int N_VEC        = 12;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT      = N_VEC * 40 + RESET_CYCLES;

    typedef struct packed {
        logic [31:0]              word;
        logic                     pred;
        logic                     ferr;
        logic                     mis;
        logic [1:0]               used;      // Read ports used, {rs1, rs2}
        f_part_t                  f;
        rf_add_t                  rd;
        rf_add_t                  rs1;
        rf_add_t                  rs2;
        logic [`ID_PAYLOAD_W-1:0] payload;
        ictrl_t                   ictrl;
        imiscon_t                 imiscon;
    } vec_t;

    logic       clk;
    logic       rst_n;
    logic       fe_valid;
    fe_packet_t fe_packet;
    logic       stall;
    logic       flush;
    logic       cfg_we;
    hrd_ctrl_t  cfg_wdata;
    logic       stall_o;
    idop_t      idop;

    vec_t    vecs [N_VEC];
    string   names [N_VEC];
    int      cycles = 0;
    rf_add_t acm_model;
    logic    scrub_on;

    // Table entries used in the scrub phase: LUI, ADDI, LUI, ADD, ADDI
    int v_idx_list [5] = '{7, 2, 7, 0, 2};

    tb_clock_gen clk_gen_i (.clk_o(clk));

    id_stage_top id_stage_top_i (
        .clk_i(clk), .rst_n_i(rst_n), .fe_valid_i(fe_valid), .fe_packet_i(fe_packet),
        .stall_i(stall), .flush_i(flush), .cfg_we_i(cfg_we), .cfg_wdata_i(cfg_wdata),
        .stall_o(stall_o), .idop_o(idop)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic rf_add_t next_acm(rf_add_t a);
        return (a == rf_add_t'(`ID_ACM_LAST)) ? rf_add_t'(`ID_ACM_FIRST) : a + rf_add_t'(1);
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(string what, logic cond);
        assert (cond === 1'b1) else begin
            $display("Check failed: %s", what);
            $display("TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_instr(vec_t v, logic fl);
        @(posedge clk);
        fe_valid  <= 1'b1;
        fe_packet <= '{v.word, v.pred, v.ferr, v.mis};
        flush     <= fl;
        cfg_we    <= 1'b0;
        if (scrub_on && (fl || v.used != 2'b11)) begin
            acm_model = next_acm(acm_model);
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        fe_valid  <= 1'b0;
        fe_packet <= '0;
        flush     <= 1'b0;
        cfg_we    <= 1'b0;
        if (scrub_on && !stall) begin
            acm_model = next_acm(acm_model);    // Empty slot frees port 2
        end
    endtask

    task automatic write_cfg(hrd_ctrl_t c);
        @(posedge clk);
        fe_valid  <= 1'b0;
        cfg_we    <= 1'b1;
        cfg_wdata <= c;
        if (scrub_on) begin
            acm_model = next_acm(acm_model);
        end
        scrub_on = c.scrub_en;
        drive_idle();
    endtask

    task automatic check_decoded(string name, vec_t v);
        sctrl_t s;
        // Ports in use, and x0 sources among them
        s.rfrp1 = v.used[1];
        s.rfrp2 = v.used[0];
        s.zero1 = v.used[1] && (v.rs1 == '0);
        s.zero2 = v.used[0] && (v.rs2 == '0);
        check_val({name, " f"}, 32'(v.f), 32'(idop.f));
        check_val({name, " rd"}, 32'(v.rd), 32'(idop.rd));
        check_val({name, " payload"}, 32'(v.payload), 32'(idop.payload));
        check_val({name, " sctrl"}, 32'(s), 32'(idop.sctrl));
        check_val({name, " ictrl"}, 32'(v.ictrl), 32'(idop.ictrl));
        check_val({name, " imiscon"}, 32'(v.imiscon), 32'(idop.imiscon));
        if (v.used[1]) check_val({name, " rs1"}, 32'(v.rs1), 32'(idop.rs1));
        if (v.used[0]) check_val({name, " rs2"}, 32'(v.rs2), 32'(idop.rs2));
    endtask

    task automatic check_empty(string name);
        check_val({name, " ictrl"}, 32'd0, 32'(idop.ictrl));
        check_val({name, " imiscon"}, 32'(IMISCON_FREE), 32'(idop.imiscon));
    endtask

    initial begin
        rf_add_t saved;
        int      n;
        int      wait_n;
        vec_t    v;

        void'($urandom(32'h575f_de71));
        vecs[0]  = '{32'h002081B3, 0, 0, 0, 2'b11, 4'h0, 5'd3, 5'd1, 5'd2, 21'd0,
                     7'b1000000, IMISCON_FREE};
        vecs[1]  = '{32'h407302B3, 0, 0, 0, 2'b11, 4'h8, 5'd5, 5'd6, 5'd7, 21'd0,
                     7'b1000000, IMISCON_FREE};
        vecs[2]  = '{32'hFFB08213, 0, 0, 0, 2'b10, 4'h0, 5'd4, 5'd1, 5'd0, 21'h1FFFFB,
                     7'b1000000, IMISCON_FREE};
        vecs[3]  = '{32'h00812383, 0, 0, 0, 2'b10, 4'h2, 5'd7, 5'd2, 5'd0, 21'd8,
                     7'b0100000, IMISCON_FREE};
        vecs[4]  = '{32'h0051A623, 0, 0, 0, 2'b11, 4'h2, 5'd0, 5'd3, 5'd5, 21'd12,
                     7'b0010000, IMISCON_FREE};
        vecs[5]  = '{32'h00208863, 1, 0, 0, 2'b11, 4'h8, 5'd0, 5'd1, 5'd2, 21'd16,
                     7'b0001000, IMISCON_FREE};
        vecs[6]  = '{32'h001000EF, 0, 0, 0, 2'b00, 4'h0, 5'd1, 5'd0, 5'd0, 21'h800,
                     7'b0000100, IMISCON_FREE};
        vecs[7]  = '{32'h12345537, 0, 0, 0, 2'b00, 4'h0, 5'd10, 5'd0, 5'd0, 21'h12345,
                     7'b0000010, IMISCON_FREE};
        vecs[8]  = '{32'hFFFFF597, 0, 0, 0, 2'b00, 4'h0, 5'd11, 5'd0, 5'd0, 21'h1FFFFF,
                     7'b0000001, IMISCON_FREE};
        vecs[9]  = '{32'hFFFFFFFF, 0, 0, 0, 2'b00, 4'h7, 5'd31, 5'd0, 5'd0, 21'd0,
                     7'b0000000, IMISCON_ILLEGAL};
        vecs[10] = '{32'h002081B3, 0, 1, 0, 2'b11, 4'h0, 5'd3, 5'd1, 5'd2, 21'd0,
                     7'b1000000, IMISCON_FETCH_ERR};
        vecs[11] = '{32'h12345537, 0, 0, 1, 2'b00, 4'h0, 5'd10, 5'd0, 5'd0, 21'h12345,
                     7'b0000010, IMISCON_ILLEGAL};
        names = '{"ADD", "SUB", "ADDI", "LW", "SW", "BEQ", "JAL", "LUI", "AUIPC",
                  "illegal", "fetch error", "misaligned"};

        rst_n     <= 1'b0;
        fe_valid  <= 1'b0;
        fe_packet <= '0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        cfg_we    <= 1'b0;
        cfg_wdata <= '0;
        acm_model = rf_add_t'(`ID_ACM_FIRST);
        scrub_on  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Decode table with random bubbles in between
        for (int i = 0; i < N_VEC; i++) begin
            drive_instr(vecs[i], 1'b0);
            drive_idle();
            @(negedge clk);
            check_decoded({"decode ", names[i]}, vecs[i]);
            n = $urandom_range(2, 0);
            repeat (n) begin
                drive_idle();
                @(negedge clk);
                check_empty("bubble");
            end
        end

        drive_instr(vecs[0], 1'b1);
        drive_idle();
        @(negedge clk);
        check_empty("flush");

        // Stall over a valid slot, second instruction waits in the aligner
        drive_instr(vecs[0], 1'b0);
        drive_instr(vecs[1], 1'b0);
        stall <= 1'b1;
        drive_idle();
        @(negedge clk);
        check_decoded("stall hold ADD", vecs[0]);
        check_val("stall_o raised", 32'd1, 32'(stall_o));
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_decoded("stall hold again", vecs[0]);
        @(negedge clk);
        check_decoded("stall release SUB", vecs[1]);
        check_val("stall_o released", 32'd0, 32'(stall_o));

        write_cfg('{1'b1, 1'b0});
        foreach (v_idx_list[k]) begin
            v     = vecs[v_idx_list[k]];
            saved = acm_model;
            drive_instr(v, 1'b0);
            drive_idle();
            @(negedge clk);
            if (v.used[0]) check_val("scrub used rs2", 32'(v.rs2), 32'(idop.rs2));
            else check_val({"scrub ", names[v_idx_list[k]]}, 32'(saved), 32'(idop.rs2));
        end
        drive_instr(vecs[0], 1'b1);
        drive_idle();
        @(negedge clk);
        check_empty("scrub flush");
        repeat (40) drive_idle();    // Enough to wrap the search address
        saved = acm_model;
        drive_instr(vecs[7], 1'b0);
        drive_idle();
        @(negedge clk);
        check_val("scrub after wrap", 32'(saved), 32'(idop.rs2));

        // Watchdog under a held stall
        write_cfg('{1'b1, 1'b1});
        drive_instr(vecs[0], 1'b0);
        stall <= 1'b1;
        drive_idle();
        wait_n = 0;
        while (idop.imiscon != IMISCON_DSCR && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        check_true("watchdog inserted no discard bubble within 16 stalled cycles",
                   idop.imiscon == IMISCON_DSCR && wait_n <= 16);
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);

        if (id_stage_top_i.u_assertions.fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_id_assertions.sv ====
// Decode stage protocol checks
// Reset, flush and scrub address properties bound to the stage top level

`timescale 1ns/1ps

module tb_id_assertions import id_pkg::*; (
    input logic    clk_i,
    input logic    rst_n_i,
    input logic    flush_i,
    input logic    stall_o,
    input idop_t   idop_o,
    input rf_add_t acm_add_i
);

    int fails = 0;

    // No stall to fetch right after reset
    stall_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !stall_o)
        else begin
            $error("stall_o high in the cycle after reset");
            fails++;
        end

    flush_empties_idop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (idop_o.ictrl == '0) && (idop_o.imiscon == IMISCON_FREE))
        else begin
            $error("IDOP slot not empty after a flush");
            fails++;
        end

    // x0 is never part of the search
    scrub_add_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        acm_add_i != '0)
        else begin
            $error("Scrub address is zero");
            fails++;
        end

endmodule

bind id_stage_top tb_id_assertions u_assertions (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i), .stall_o(stall_o),
    .idop_o(idop_o), .acm_add_i(acm_add)
);

// ==== tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock with a 100 ns period

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #50 clk_o = ~clk_o;    // Half period

endmodule

// ==== id_stage_top.sv ====
// Instruction decode stage
// Aligner, decoder, hardening config, scrubber and IDOP register

`timescale 1ns/1ps

module id_stage_top import id_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       fe_valid_i,
    input  fe_packet_t fe_packet_i,
    input  logic       stall_i,
    input  logic       flush_i,
    input  logic       cfg_we_i,
    input  hrd_ctrl_t  cfg_wdata_i,
    output logic       stall_o,
    output idop_t      idop_o
);

    instr_u    al_instr;
    idop_t     dec;
    hrd_ctrl_t ctrl;
    rf_add_t   acm_add;
    logic      al_nop, al_pred, al_ferr, al_aerr;
    logic      restart, advance, idop_empty;
    logic      stall_id, flush_id;

    assign stall_id = stall_i && !idop_empty;    // Stall only over an executable slot
    assign flush_id = flush_i || restart;

    id_aligner m_aligner (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall_id), .flush_i(flush_id),
        .fe_valid_i(fe_valid_i), .fe_packet_i(fe_packet_i), .stall_o(stall_o),
        .nop_o(al_nop), .instr_o(al_instr), .pred_o(al_pred), .ferr_o(al_ferr),
        .aerr_o(al_aerr)
    );

    id_decoder m_decoder (
        .instr_i(al_instr), .pred_i(al_pred), .ferr_i(al_ferr), .aerr_i(al_aerr),
        .dec_o(dec)
    );

    id_hrd_ctrl m_hrd_ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg_we_i(cfg_we_i),
        .cfg_wdata_i(cfg_wdata_i), .ctrl_o(ctrl)
    );

    id_acm_scrubber m_scrubber (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .ctrl_i(ctrl), .flush_i(flush_id),
        .advance_i(advance), .acm_add_o(acm_add), .restart_o(restart)
    );

    id_idop_reg m_idop_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .dec_i(dec), .nop_i(al_nop),
        .stall_i(stall_id), .flush_i(flush_id), .restart_i(restart),
        .scrub_en_i(ctrl.scrub_en), .acm_add_i(acm_add), .idop_o(idop_o),
        .empty_o(idop_empty), .advance_o(advance)
    );

endmodule

// ==== id_idop_reg.sv ====
// IDOP pipeline register
// Holds the decoded instruction, handles stall and flush, inserts scrub addresses

`timescale 1ns/1ps

module id_idop_reg import id_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  idop_t   dec_i,
    input  logic    nop_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  logic    restart_i,
    input  logic    scrub_en_i,
    input  rf_add_t acm_add_i,
    output idop_t   idop_o,
    output logic    empty_o,
    output logic    advance_o
);

    idop_t    idop_q;
    ictrl_t   ictrl_d;
    imiscon_t imiscon_d;
    rf_add_t  rs1_d, rs2_d;
    logic     we_esn, we_aux, we_rs1, we_rs2;
    logic [1:0] id_free, op_free;    // Ports unused by the new and the held instruction

    assign we_esn = flush_i || !stall_i;
    assign we_aux = !(flush_i || stall_i || nop_i);

    always_comb begin
        ictrl_d   = dec_i.ictrl;
        imiscon_d = dec_i.imiscon;
        if (flush_i || nop_i) begin
            ictrl_d   = '0;
            imiscon_d = restart_i ? IMISCON_DSCR : IMISCON_FREE;
        end
    end

    assign id_free[0] = dec_i.sctrl.zero1 || !dec_i.sctrl.rfrp1;
    assign id_free[1] = dec_i.sctrl.zero2 || !dec_i.sctrl.rfrp2;
    // A discarded slot needs no operands
    assign op_free[0] = idop_q.sctrl.zero1 || !idop_q.sctrl.rfrp1 ||
                        (idop_q.imiscon == IMISCON_DSCR);
    assign op_free[1] = idop_q.sctrl.zero2 || !idop_q.sctrl.rfrp2 ||
                        (idop_q.imiscon == IMISCON_DSCR);

    // Port 2 takes the search address first, port 1 only when port 2 is busy
    always_comb begin
        rs1_d = dec_i.rs1;
        rs2_d = dec_i.rs2;
        if (scrub_en_i) begin
            we_rs1 = !nop_i && !(id_free[0] && id_free[1]);
            we_rs2 = 1'b1;
            rs1_d  = (we_aux && !id_free[0]) ? dec_i.rs1 : acm_add_i;
            rs2_d  = (we_aux && !id_free[1]) ? dec_i.rs2 : acm_add_i;
            if (flush_i) begin
                we_rs1 = 1'b0;
            end else if (stall_i) begin
                we_rs1 = op_free[0] && !op_free[1];
                we_rs2 = op_free[1];
            end
        end else begin
            we_rs1 = we_aux && !id_free[0];
            we_rs2 = we_aux && !id_free[1];
        end
    end

    assign advance_o = scrub_en_i && (stall_i ? (op_free != 2'b00) :
                                                ((id_free != 2'b00) || nop_i));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idop_q.ictrl   <= '0;
            idop_q.imiscon <= IMISCON_FREE;
        end else if (we_esn) begin
            idop_q.ictrl   <= ictrl_d;
            idop_q.imiscon <= imiscon_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_aux) begin
            idop_q.payload <= dec_i.payload;
            idop_q.f       <= dec_i.f;
            idop_q.rd      <= dec_i.rd;
            idop_q.sctrl   <= dec_i.sctrl;
        end
        if (we_rs1) begin
            idop_q.rs1 <= rs1_d;
        end
        if (we_rs2) begin
            idop_q.rs2 <= rs2_d;
        end
    end

    assign empty_o = (idop_q.ictrl == '0) && (idop_q.imiscon == IMISCON_FREE);
    assign idop_o  = idop_q;

endmodule

// ==== id_acm_scrubber.sv ====
// Read-port scrub address generator
// Rolling search address over x1..x31 and an idle watchdog that requests a restart

`timescale 1ns/1ps
`include "id_defines.svh"

module id_acm_scrubber import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  hrd_ctrl_t ctrl_i,
    input  logic      flush_i,
    input  logic      advance_i,
    output rf_add_t   acm_add_o,
    output logic      restart_o
);

    localparam rf_add_t ACM_FIRST = rf_add_t'(`ID_ACM_FIRST);
    localparam rf_add_t ACM_LAST  = rf_add_t'(`ID_ACM_LAST);

    rf_add_t    add_q;
    logic [3:0] wdog_q;

    // Search address moves on every freed port or flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            add_q <= ACM_FIRST;
        end else if (ctrl_i.scrub_en && (advance_i || flush_i)) begin
            if (add_q == ACM_LAST) begin
                add_q <= ACM_FIRST;          // x0 is skipped
            end else begin
                add_q <= add_q + rf_add_t'(1);
            end
        end
    end

    assign restart_o = ctrl_i.restart_en && (wdog_q == 4'(`ID_WDOG_LIMIT));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wdog_q <= '0;
        end else if (!ctrl_i.restart_en || advance_i || restart_o) begin
            wdog_q <= '0;
        end else begin
            wdog_q <= wdog_q + 4'd1;         // Search is blocked
        end
    end

    assign acm_add_o = add_q;

endmodule

// ==== id_hrd_ctrl.sv ====
// Hardening configuration register
// Enables read-port scrubbing and the restart watchdog

`timescale 1ns/1ps

module id_hrd_ctrl import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      cfg_we_i,
    input  hrd_ctrl_t cfg_wdata_i,
    output hrd_ctrl_t ctrl_o
);

    hrd_ctrl_t ctrl_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (cfg_we_i) begin
            ctrl_q.scrub_en   <= cfg_wdata_i.scrub_en;
            // Watchdog only runs on top of scrubbing
            ctrl_q.restart_en <= cfg_wdata_i.restart_en && cfg_wdata_i.scrub_en;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// ==== id_decoder.sv ====
// RV32I instruction decoder
// Produces operation fields, register addresses, immediate payload and indicators

`timescale 1ns/1ps
`include "id_defines.svh"

module id_decoder import id_pkg::*; (
    input  instr_u instr_i,
    input  logic   pred_i,
    input  logic   ferr_i,
    input  logic   aerr_i,
    output idop_t  dec_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [31:0]              w;
    logic [`ID_PAYLOAD_W-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    logic                     known;

    assign w = instr_i;

    // Sign-extended immediates for each format
    assign imm_i = {{9{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{9{w[31]}}, instr_i.r.funct7, instr_i.r.rd};
    assign imm_b = {{8{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_j = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    assign imm_u = {w[31], w[31:12]};          // Upper bits 31..12

    always_comb begin
        known            = 1'b1;
        dec_o.payload    = '0;
        dec_o.f.alt      = 1'b0;
        dec_o.f.funct3   = instr_i.r.funct3;
        dec_o.rd         = instr_i.r.rd;
        dec_o.rs1        = instr_i.r.rs1;
        dec_o.rs2        = instr_i.r.rs2;
        dec_o.sctrl      = '0;
        dec_o.ictrl      = '0;
        dec_o.imiscon    = IMISCON_FREE;

        case (instr_i.r.opcode)
            OPC_OP: begin
                dec_o.ictrl.alu   = 1'b1;
                dec_o.sctrl.rfrp1 = 1'b1;
                dec_o.sctrl.rfrp2 = 1'b1;
                dec_o.f.alt       = instr_i.r.funct7[5];    // SUB, SRA
            end
            OPC_OP_IMM: begin
                dec_o.ictrl.alu   = 1'b1;
                dec_o.sctrl.rfrp1 = 1'b1;
                dec_o.payload     = imm_i;
                if (instr_i.r.funct3 == 3'b101) begin
                    dec_o.f.alt = instr_i.r.funct7[5];      // SRAI
                end
            end
            OPC_LOAD: begin
                dec_o.ictrl.load  = 1'b1;
                dec_o.sctrl.rfrp1 = 1'b1;
                dec_o.payload     = imm_i;
            end
            OPC_STORE: begin
                dec_o.ictrl.store = 1'b1;
                dec_o.sctrl.rfrp1 = 1'b1;
                dec_o.sctrl.rfrp2 = 1'b1;
                dec_o.rd          = '0;
                dec_o.payload     = imm_s;
            end
            OPC_BRANCH: begin
                dec_o.ictrl.branch = 1'b1;
                dec_o.sctrl.rfrp1  = 1'b1;
                dec_o.sctrl.rfrp2  = 1'b1;
                dec_o.rd           = '0;
                dec_o.payload      = imm_b;
                dec_o.f.alt        = pred_i;
            end
            OPC_JAL: begin
                dec_o.ictrl.jump = 1'b1;
                dec_o.f.funct3   = 3'b000;
                dec_o.f.alt      = pred_i;
                dec_o.payload    = imm_j;
            end
            OPC_JALR: begin
                dec_o.ictrl.jump  = 1'b1;
                dec_o.sctrl.rfrp1 = 1'b1;
                dec_o.f.alt       = pred_i;
                dec_o.payload     = imm_i;
            end
            OPC_LUI: begin
                dec_o.ictrl.lui = 1'b1;
                dec_o.f.funct3  = 3'b000;
                dec_o.payload   = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.ictrl.auipc = 1'b1;
                dec_o.f.funct3    = 3'b000;
                dec_o.payload     = imm_u;
            end
            default: known = 1'b0;    // ictrl stays zero
        endcase

        dec_o.sctrl.zero1 = dec_o.sctrl.rfrp1 && (instr_i.r.rs1 == '0);
        dec_o.sctrl.zero2 = dec_o.sctrl.rfrp2 && (instr_i.r.rs2 == '0);

        // Fetch error outranks alignment and opcode problems
        if (ferr_i) begin
            dec_o.imiscon = IMISCON_FETCH_ERR;
        end else if (aerr_i || !known) begin
            dec_o.imiscon = IMISCON_ILLEGAL;
        end
    end

endmodule

// ==== id_aligner.sv ====
// Instruction aligner
// One-entry buffer that keeps a fetched instruction while decode is stalled

`timescale 1ns/1ps

module id_aligner import id_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       flush_i,
    input  logic       fe_valid_i,
    input  fe_packet_t fe_packet_i,
    output logic       stall_o,
    output logic       nop_o,
    output instr_u     instr_o,
    output logic       pred_o,
    output logic       ferr_o,
    output logic       aerr_o
);

    fe_packet_t buf_q;
    fe_packet_t sel;
    logic       buf_v_q;
    logic       capture;

    // Instruction arrives while the stage cannot accept it
    assign capture = stall_i && fe_valid_i && !buf_v_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            buf_v_q <= 1'b0;
        end else if (flush_i) begin
            buf_v_q <= 1'b0;              // Buffered instruction is dropped
        end else if (capture) begin
            buf_v_q <= 1'b1;
        end else if (!stall_i) begin
            buf_v_q <= 1'b0;              // Drains into IDOP at this edge
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            buf_q <= fe_packet_i;
        end
    end

    // Buffer has priority over the fetch port
    assign sel     = buf_v_q ? buf_q : fe_packet_i;
    assign stall_o = buf_v_q;
    assign nop_o   = !(buf_v_q || fe_valid_i);
    assign instr_o = sel.instr;
    assign pred_o  = sel.pred;
    assign ferr_o  = sel.ferr;
    assign aerr_o  = sel.misaligned;

endmodule

// ==== id_pkg.sv ====
// Decode stage types
// Instruction formats, fetch packet, IDOP register fields and configuration

`include "id_defines.svh"

package id_pkg;

    typedef logic [`ID_RF_AW-1:0] rf_add_t;

    typedef struct packed {
        logic       alt;       // funct7[5], or prediction for control flow
        logic [2:0] funct3;
    } f_part_t;

    typedef struct packed {
        logic rfrp1;           // Read port 1 used
        logic rfrp2;           // Read port 2 used
        logic zero1;           // Source 1 is x0
        logic zero2;           // Source 2 is x0
    } sctrl_t;

    // All zero marks an empty slot
    typedef struct packed {
        logic alu;
        logic load;
        logic store;
        logic branch;
        logic jump;
        logic lui;
        logic auipc;
    } ictrl_t;

    typedef enum logic [1:0] {
        IMISCON_FREE      = 2'b00,
        IMISCON_ILLEGAL   = 2'b01,
        IMISCON_FETCH_ERR = 2'b10,
        IMISCON_DSCR      = 2'b11    // Discard bubble
    } imiscon_t;

    typedef struct packed {
        logic [6:0] funct7;
        rf_add_t    rs2;
        rf_add_t    rs1;
        logic [2:0] funct3;
        rf_add_t    rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rf_add_t     rs1;
        logic [2:0]  funct3;
        rf_add_t     rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same instruction word seen through two formats
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef struct packed {
        logic [31:0] instr;
        logic        pred;        // Predicted taken
        logic        ferr;        // Fetch bus error
        logic        misaligned;
    } fe_packet_t;

    typedef struct packed {
        logic [`ID_PAYLOAD_W-1:0] payload;
        f_part_t                  f;
        rf_add_t                  rd;
        rf_add_t                  rs1;
        rf_add_t                  rs2;
        sctrl_t                   sctrl;
        ictrl_t                   ictrl;
        imiscon_t                 imiscon;
    } idop_t;

    typedef struct packed {
        logic scrub_en;
        logic restart_en;
    } hrd_ctrl_t;

endpackage

// ==== id_defines.svh ====
// Decode stage parameters
// Register address and payload widths, scrub range and watchdog limit

`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Register file addressing
`define ID_RF_AW       5

// Immediate payload carried to the operand stage
`define ID_PAYLOAD_W   21

// Scrub search range, x0 is never searched
`define ID_ACM_FIRST   1
`define ID_ACM_LAST    31

`define ID_WDOG_LIMIT  15    // Idle cycles before a forced restart

`endif
